// ==== include/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

////////////////////
// Datapath widths
////////////////////

// Operand and result width of the integer datapath
`define RV_DATA_WIDTH 32

// Program counter and branch target width
`define RV_ADDRESS_WIDTH 32

// Architectural register index for x0 to x31
`define RV_REG_IDX_WIDTH 5

`endif

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

`include "rv_settings.svh"

package rv_isa_pkg;

    ////////////////////
    // ALU operations
    ////////////////////

    // Branch compares put their outcome in bit 0 of the result
    typedef enum logic [3:0] {
        ALU_ADD     = 4'd0,
        ALU_SUB     = 4'd1,
        ALU_AND     = 4'd2,
        ALU_OR      = 4'd3,
        ALU_XOR     = 4'd4,
        ALU_SLL     = 4'd5,
        ALU_SRL     = 4'd6,
        ALU_SRA     = 4'd7,
        ALU_SLT     = 4'd8,
        ALU_SLTU    = 4'd9,
        ALU_PASS_B  = 4'd10,
        ALU_CMP_EQ  = 4'd11,
        ALU_CMP_LT  = 4'd12,
        ALU_CMP_LTU = 4'd13
    } alu_op_e;

    ////////////////////
    // Instruction fields
    ////////////////////

    // Kept at its instruction bit positions, so bit 12 picks the inverted compare
    typedef logic [14:12] funct3_t;

    typedef logic [`RV_REG_IDX_WIDTH-1:0] reg_idx_t;

    // x0 reads as zero and is never a forward source
    localparam reg_idx_t REG_ZERO = '0;

    ////////////////////
    // Forward selects
    ////////////////////

    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_MEM = 2'b01,
        FWD_WB  = 2'b10
    } fwd_sel_e;

endpackage

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`default_nettype none

`include "rv_settings.svh"

package rv_pipe_pkg;

    ////////////////////
    // ID/EX payload
    ////////////////////

    // Decoded instruction as handed over by decode
    typedef struct packed {
        logic                           valid;
        logic                           reg_write;
        logic [1:0]                     res_src;
        logic                           mem_write;
        logic                           jump;
        logic                           branch;
        rv_isa_pkg::alu_op_e            alu_op;
        rv_isa_pkg::funct3_t            funct3;
        // Operand a from pc, operand b from imm
        logic                           alu_src_a;
        logic                           alu_src_b;
        // Target base from rs1 instead of pc
        logic                           adder_src;
        logic [`RV_DATA_WIDTH-1:0]      rd1;
        logic [`RV_DATA_WIDTH-1:0]      rd2;
        logic [`RV_ADDRESS_WIDTH-1:0]   pc;
        rv_isa_pkg::reg_idx_t           rs1;
        rv_isa_pkg::reg_idx_t           rs2;
        rv_isa_pkg::reg_idx_t           rd;
        logic [`RV_DATA_WIDTH-1:0]      imm;
        logic [`RV_ADDRESS_WIDTH-1:0]   pc_plus4;
    } dec_instr_t;

    ////////////////////
    // EX/MEM payload
    ////////////////////

    typedef struct packed {
        logic                           valid;
        logic                           reg_write;
        logic [1:0]                     res_src;
        logic                           mem_write;
        rv_isa_pkg::funct3_t            funct3;
        logic [`RV_DATA_WIDTH-1:0]      alu_result;
        // Store data after forwarding
        logic [`RV_DATA_WIDTH-1:0]      write_data;
        rv_isa_pkg::reg_idx_t           rd;
        logic [`RV_ADDRESS_WIDTH-1:0]   pc_plus4;
    } ex_out_t;

    ////////////////////
    // MEM/WB payload
    ////////////////////

    typedef struct packed {
        logic                           valid;
        logic                           reg_write;
        rv_isa_pkg::reg_idx_t           rd;
        logic [`RV_DATA_WIDTH-1:0]      result;
    } wb_t;

    // Fetch redirect from a taken branch or jump
    typedef struct packed {
        logic                           taken;
        logic [`RV_ADDRESS_WIDTH-1:0]   target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== design/stage_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  PAYLOAD_T d,
    output PAYLOAD_T q
);

    ////////////////////
    // Stage register
    ////////////////////

    // A cleared payload is a bubble since valid sits in the top bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Once out of reset the stage must never carry X into the next stage
    q_known_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(q)
    ) else $error("stage_reg holds unknown bits");

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module alu (
    input  logic [`RV_DATA_WIDTH-1:0] a,
    input  logic [`RV_DATA_WIDTH-1:0] b,
    input  rv_isa_pkg::alu_op_e       op,
    input  logic                      funct3_b0,
    output logic [`RV_DATA_WIDTH-1:0] result
);

    import rv_isa_pkg::*;

    localparam int SHAMT_W = $clog2(`RV_DATA_WIDTH);

    logic [SHAMT_W-1:0] shamt;
    logic               eq;
    logic               lt_s;
    logic               lt_u;

    ////////////////////
    // Shared compares
    ////////////////////

    // Shift amount from the low bits of b only
    assign shamt = b[SHAMT_W-1:0];
    assign eq    = (a == b);
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    ////////////////////
    // Operation select
    ////////////////////

    always_comb begin
        result = '0;
        case (op)
            ALU_ADD:     result = a + b;
            ALU_SUB:     result = a - b;
            ALU_AND:     result = a & b;
            ALU_OR:      result = a | b;
            ALU_XOR:     result = a ^ b;
            ALU_SLL:     result = a << shamt;
            ALU_SRL:     result = a >> shamt;
            ALU_SRA:     result = $unsigned($signed(a) >>> shamt);
            ALU_SLT:     result[0] = lt_s;
            ALU_SLTU:    result[0] = lt_u;
            // lui brings its imm on b
            ALU_PASS_B:  result = b;
            // funct3 bit 12 turns beq/blt/bltu into bne/bge/bgeu
            ALU_CMP_EQ:  result[0] = eq ^ funct3_b0;
            ALU_CMP_LT:  result[0] = lt_s ^ funct3_b0;
            ALU_CMP_LTU: result[0] = lt_u ^ funct3_b0;
            default:     result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/forward_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module forward_unit (
    input  rv_isa_pkg::reg_idx_t  rs1,
    input  rv_isa_pkg::reg_idx_t  rs2,
    input  rv_pipe_pkg::ex_out_t  mem_stage,
    input  rv_pipe_pkg::wb_t      wb_stage,
    output rv_isa_pkg::fwd_sel_e  fwd_a,
    output rv_isa_pkg::fwd_sel_e  fwd_b
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    ////////////////////
    // Source select
    ////////////////////

    // Youngest writer wins, so the memory stage is checked first
    function automatic fwd_sel_e pick_source(
        input reg_idx_t rs,
        input ex_out_t  mem,
        input wb_t      wb
    );
        fwd_sel_e sel;
        sel = FWD_RF;
        if (rs != REG_ZERO) begin
            if (mem.valid && mem.reg_write && (mem.rd == rs)) begin
                sel = FWD_MEM;
            end else if (wb.valid && wb.reg_write && (wb.rd == rs)) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign fwd_a = pick_source(rs1, mem_stage, wb_stage);
    assign fwd_b = pick_source(rs2, mem_stage, wb_stage);

endmodule

`default_nettype wire

// ==== design/execute.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module execute (
    input  rv_pipe_pkg::dec_instr_t    instr,
    input  logic [`RV_DATA_WIDTH-1:0]  alu_result_m,
    input  logic [`RV_DATA_WIDTH-1:0]  result_w,
    input  rv_isa_pkg::fwd_sel_e       fwd_a,
    input  rv_isa_pkg::fwd_sel_e       fwd_b,
    output rv_pipe_pkg::ex_out_t       ex_out,
    output rv_pipe_pkg::redirect_t     redirect
);

    import rv_isa_pkg::*;

    logic [`RV_DATA_WIDTH-1:0]    a_fwd;
    logic [`RV_DATA_WIDTH-1:0]    b_fwd;
    logic [`RV_DATA_WIDTH-1:0]    a_alu;
    logic [`RV_DATA_WIDTH-1:0]    b_alu;
    logic [`RV_DATA_WIDTH-1:0]    alu_result;
    logic [`RV_ADDRESS_WIDTH-1:0] target_base;

    ////////////////////
    // Forwarding muxes
    ////////////////////

    function automatic logic [`RV_DATA_WIDTH-1:0] fwd_mux(
        input fwd_sel_e                  sel,
        input logic [`RV_DATA_WIDTH-1:0] rf_val,
        input logic [`RV_DATA_WIDTH-1:0] mem_val,
        input logic [`RV_DATA_WIDTH-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign a_fwd = fwd_mux(fwd_a, instr.rd1, alu_result_m, result_w);
    assign b_fwd = fwd_mux(fwd_b, instr.rd2, alu_result_m, result_w);

    // Operand a takes pc for auipc and b takes imm for I-type
    assign a_alu = instr.alu_src_a ? instr.pc  : a_fwd;
    assign b_alu = instr.alu_src_b ? instr.imm : b_fwd;

    alu u_alu (
        .a         (a_alu),
        .b         (b_alu),
        .op        (instr.alu_op),
        .funct3_b0 (instr.funct3[12]),
        .result    (alu_result)
    );

    ////////////////////
    // Branch and target
    ////////////////////

    // jalr needs the forwarded rs1, not the stale register file value
    assign target_base     = instr.adder_src ? a_fwd : instr.pc;
    assign redirect.target = target_base + instr.imm;
    assign redirect.taken  = instr.valid & (instr.jump | (instr.branch & alu_result[0]));

    ////////////////////
    // Outputs to EX/MEM
    ////////////////////

    assign ex_out.valid      = instr.valid;
    assign ex_out.reg_write  = instr.reg_write;
    assign ex_out.res_src    = instr.res_src;
    assign ex_out.mem_write  = instr.mem_write;
    assign ex_out.funct3     = instr.funct3;
    assign ex_out.alu_result = alu_result;
    // Store data taken ahead of the imm mux
    assign ex_out.write_data = b_fwd;
    assign ex_out.rd         = instr.rd;
    assign ex_out.pc_plus4   = instr.pc_plus4;

    ////////////////////
    // Checks
    ////////////////////

    // The forward muxes have no leg for the fourth select code
    always_comb begin
        assert (fwd_a inside {FWD_RF, FWD_MEM, FWD_WB})
            else $error("fwd_a uses an undefined select");
        assert (fwd_b inside {FWD_RF, FWD_MEM, FWD_WB})
            else $error("fwd_b uses an undefined select");
    end

    // Decode must never mark one instruction as both jump and branch
    always_comb begin
        if (instr.valid) begin
            assert (!(instr.jump && instr.branch))
                else $error("jump and branch both set");
        end
    end

endmodule

`default_nettype wire

// ==== design/ex_pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_pipeline (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_pipe_pkg::dec_instr_t instr,
    output rv_pipe_pkg::redirect_t  redirect,
    output rv_pipe_pkg::ex_out_t    mem_stage
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    dec_instr_t id_ex;
    ex_out_t    ex_out;
    wb_t        wb_d;
    wb_t        wb_stage;
    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;

    ////////////////////
    // ID/EX
    ////////////////////

    // A taken redirect turns the next instruction into a bubble
    stage_reg #(
        .PAYLOAD_T (dec_instr_t)
    ) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (redirect.taken),
        .d     (instr),
        .q     (id_ex)
    );

    ////////////////////
    // Execute
    ////////////////////

    forward_unit u_forward_unit (
        .rs1       (id_ex.rs1),
        .rs2       (id_ex.rs2),
        .mem_stage (mem_stage),
        .wb_stage  (wb_stage),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b)
    );

    execute u_execute (
        .instr        (id_ex),
        .alu_result_m (mem_stage.alu_result),
        .result_w     (wb_stage.result),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .ex_out       (ex_out),
        .redirect     (redirect)
    );

    ////////////////////
    // EX/MEM and MEM/WB
    ////////////////////

    stage_reg #(
        .PAYLOAD_T (ex_out_t)
    ) u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (1'b0),
        .d     (ex_out),
        .q     (mem_stage)
    );

    // No loads, so the ALU result is the writeback value
    assign wb_d = '{
        valid:     mem_stage.valid,
        reg_write: mem_stage.reg_write,
        rd:        mem_stage.rd,
        result:    mem_stage.alu_result
    };

    stage_reg #(
        .PAYLOAD_T (wb_t)
    ) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (1'b0),
        .d     (wb_d),
        .q     (wb_stage)
    );

endmodule

`default_nettype wire

// ==== verif/tb_ex_pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module tb_ex_pipeline;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int NUM_INSTR      = 400;
    localparam int DRAIN_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = NUM_INSTR + 20;

    typedef logic [`RV_DATA_WIDTH-1:0] word_t;

    // Expected contents of one pipeline slot
    typedef struct packed {
        ex_out_t   ex;
        redirect_t redir;
    } expect_t;

    logic        clk;
    logic        rst_n;
    dec_instr_t  instr;
    redirect_t   redirect;
    ex_out_t     mem_stage;
    logic [31:0] lcg_state = 32'd55;
    word_t       arch_regs [8];
    logic        slot_wr [2];
    reg_idx_t    slot_rd [2];
    logic        prev_taken;
    // Entry 0 sits in EX/MEM, entry 1 in ID/EX, entry 2 is on the input
    expect_t     exp_q [$];
    int          n_checked = 0;
    int          n_survived = 0;
    int          cycles = 0;

    ex_pipeline dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .redirect  (redirect),
        .mem_stage (mem_stage)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b, logic invert);
        case (op)
            ALU_ADD:     return a + b;
            ALU_SUB:     return a - b;
            ALU_AND:     return a & b;
            ALU_OR:      return a | b;
            ALU_XOR:     return a ^ b;
            ALU_SLL:     return a << b[4:0];
            ALU_SRL:     return a >> b[4:0];
            ALU_SRA:     return $signed(a) >>> b[4:0];
            ALU_SLT:     return word_t'($signed(a) < $signed(b));
            ALU_SLTU:    return word_t'(a < b);
            ALU_PASS_B:  return b;
            // bne, bge and bgeu flip the plain compare
            ALU_CMP_EQ:  return word_t'((a == b) ^ invert);
            ALU_CMP_LT:  return word_t'(($signed(a) < $signed(b)) ^ invert);
            ALU_CMP_LTU: return word_t'((a < b) ^ invert);
            default:     return '0;
        endcase
    endfunction

    // Branch outcome by mnemonic as the ISA defines it
    function automatic logic branch_cond(funct3_t f3, word_t v1, word_t v2);
        case (f3)
            3'b000:  return v1 == v2;
            3'b001:  return v1 != v2;
            3'b100:  return $signed(v1) < $signed(v2);
            3'b101:  return $signed(v1) >= $signed(v2);
            3'b110:  return v1 < v2;
            3'b111:  return v1 >= v2;
            default: return 1'b0;
        endcase
    endfunction

    // v1 and v2 are the architectural values of rs1 and rs2
    function automatic expect_t ref_execute(dec_instr_t ins, word_t v1, word_t v2);
        expect_t e;
        word_t   a;
        word_t   b;
        e = '0;
        a = ins.alu_src_a ? ins.pc : v1;
        b = ins.alu_src_b ? ins.imm : v2;
        e.ex.valid      = ins.valid;
        e.ex.reg_write  = ins.reg_write;
        e.ex.res_src    = ins.res_src;
        e.ex.mem_write  = ins.mem_write;
        e.ex.funct3     = ins.funct3;
        e.ex.alu_result = ref_alu(ins.alu_op, a, b, ins.funct3[12]);
        e.ex.write_data = v2;
        e.ex.rd         = ins.rd;
        e.ex.pc_plus4   = ins.pc_plus4;
        e.redir.taken   = ins.valid &&
            (ins.jump || (ins.branch && branch_cond(ins.funct3, v1, v2)));
        e.redir.target  = (ins.adder_src ? v1 : ins.pc) + ins.imm;
        return e;
    endfunction

    // Writer of rs among the two slots ahead
    function automatic logic in_flight(reg_idx_t rs);
        logic hit;
        hit = (slot_wr[0] && slot_rd[0] == rs) || (slot_wr[1] && slot_rd[1] == rs);
        return hit && (rs != REG_ZERO);
    endfunction

    function automatic dec_instr_t random_instr(logic [`RV_ADDRESS_WIDTH-1:0] pc);
        dec_instr_t  ins;
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  sel;
        logic [2:0]  f3;
        r = next_random();
        s = next_random();
        sel = r[27:24];
        if (sel > 4'd9) sel = sel - 4'd6;
        f3 = r[26:24];
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;
        ins = '0;
        ins.valid     = 1'b1;
        ins.reg_write = 1'b1;
        ins.res_src   = r[14:13];
        ins.alu_op    = alu_op_e'(sel);
        ins.funct3    = s[14:12];
        // Indices 0 to 7 keep hazards frequent
        ins.rs1       = {2'b00, r[23:21]};
        ins.rs2       = {2'b00, r[20:18]};
        ins.rd        = {2'b00, r[17:15]};
        ins.imm       = {{20{s[11]}}, s[11:0]};
        ins.pc        = pc;
        ins.pc_plus4  = pc + 32'd4;
        case (r[31:28])
            4'd6, 4'd7, 4'd8: begin
                ins.alu_src_b = 1'b1;
                if (ins.alu_op == ALU_SUB) ins.alu_op = ALU_ADD;
            end
            4'd9: begin
                ins.reg_write = 1'b0;
                ins.mem_write = 1'b1;
                ins.alu_op    = ALU_ADD;
                ins.alu_src_b = 1'b1;
            end
            4'd10, 4'd11: begin
                ins.alu_op    = (r[28]) ? ALU_ADD : ALU_PASS_B;
                ins.alu_src_a = r[28];
                ins.alu_src_b = 1'b1;
                ins.imm       = {s[31:12], 12'b0};
            end
            4'd12, 4'd13: begin
                ins.reg_write = 1'b0;
                ins.branch    = 1'b1;
                ins.funct3    = f3;
                ins.alu_op    = !f3[2] ? ALU_CMP_EQ : (f3[1] ? ALU_CMP_LTU : ALU_CMP_LT);
                ins.imm       = {{19{s[12]}}, s[12:1], 1'b0};
            end
            4'd14, 4'd15: begin
                // jal when bit 28 is low, jalr otherwise
                ins.reg_write = 1'b0;
                ins.jump      = 1'b1;
                ins.res_src   = 2'b10;
                ins.alu_op    = ALU_ADD;
                ins.alu_src_a = !r[28];
                ins.alu_src_b = 1'b1;
                ins.adder_src = r[28];
                if (!r[28]) ins.imm = {{11{s[20]}}, s[20:1], 1'b0};
            end
            default: begin
            end
        endcase
        return ins;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_ex_out(input ex_out_t got, input ex_out_t want);
        if (want.valid) begin
            if (got !== want) begin
                fail_run($sformatf("Mismatch at %0t: mem_stage %h, expected %h",
                    $time, got, want));
            end
            n_checked++;
        end else if (got.valid !== 1'b0) begin
            fail_run($sformatf("Mismatch at %0t: mem_stage valid where a bubble belongs", $time));
        end
    endtask

    task automatic check_redirect(input redirect_t got, input redirect_t want);
        if (got.taken !== want.taken || (want.taken && got.target !== want.target)) begin
            fail_run($sformatf("Mismatch at %0t: redirect taken %b target %h, expected %b %h",
                $time, got.taken, got.target, want.taken, want.target));
        end
    endtask

    // Bubbles fill the queue through reset, so reset values are checked too
    initial begin : compare
        forever begin
            @(negedge clk);
            check_redirect(redirect, exp_q[1].redir);
            check_ex_out(mem_stage, exp_q[0].ex);
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : driver
        dec_instr_t                   ins;
        expect_t                      e;
        word_t                        v1;
        word_t                        v2;
        logic [`RV_ADDRESS_WIDTH-1:0] pc;
        rst_n = 1'b0;
        // Valid jump held on the input during reset, which reset must keep out
        instr = '0;
        instr.valid = 1'b1;
        instr.reg_write = 1'b1;
        instr.jump = 1'b1;
        instr.rd = 5'd1;
        pc = 32'h0000_1000;
        prev_taken = 1'b0;
        slot_wr[0] = 1'b0;
        slot_wr[1] = 1'b0;
        slot_rd[0] = '0;
        slot_rd[1] = '0;
        arch_regs[0] = '0;
        for (int k = 1; k < 8; k++) arch_regs[k] = next_random();
        repeat (3) exp_q.push_back('0);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int step = 0; step < NUM_INSTR + DRAIN_CYCLES; step++) begin
            ins = (step < NUM_INSTR) ? random_instr(pc) : '0;
            pc = pc + 32'd4;
            v1 = arch_regs[ins.rs1[2:0]];
            v2 = arch_regs[ins.rs2[2:0]];
            // Stale register file values that only forwarding can repair
            ins.rd1 = in_flight(ins.rs1) ? ~v1 : v1;
            ins.rd2 = in_flight(ins.rs2) ? ~v2 : v2;
            if (prev_taken) e = '0;
            else e = ref_execute(ins, v1, v2);
            slot_wr[1] = slot_wr[0];
            slot_rd[1] = slot_rd[0];
            slot_wr[0] = e.ex.valid && e.ex.reg_write;
            slot_rd[0] = ins.rd;
            if (e.ex.valid) n_survived++;
            if (slot_wr[0] && ins.rd != REG_ZERO) arch_regs[ins.rd[2:0]] = e.ex.alu_result;
            prev_taken = e.redir.taken;
            void'(exp_q.pop_front());
            exp_q.push_back(e);
            instr = ins;
            @(posedge clk);
            #1;
        end
        if (n_survived > 0 && n_checked == n_survived) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run($sformatf("Only %0d of %0d surviving instructions reached mem_stage",
                n_checked, n_survived));
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/stage_reg.sv
design/alu.sv
design/forward_unit.sv
design/execute.sv
design/ex_pipeline.sv
verif/tb_ex_pipeline.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_ex_pipeline \
    --Mdir obj_dir -o tb_ex_pipeline &&
    ./obj_dir/tb_ex_pipeline || exit 1
